// File: hdl/pipe_pkg.sv
// pipeline core definitions
package pipe_pkg;

    ////////////////////
    // sizes
    ////////////////////
    localparam int xlen        = 16;
    localparam int reg_addr_w  = 3;
    localparam int reg_count   = 8;
    localparam int imem_depth  = 32;
    localparam int imem_addr_w = 5;
    localparam int dmem_depth  = 16;
    localparam int dmem_addr_w = 4;
    localparam int seq_w       = 8;
    localparam int cyc_w       = 16;

    // instruction word: op[15:12] rd[11:9] rs1[8:6] rs2[5:3], imm[5:0]
    typedef enum logic [3:0] {
        op_nop  = 4'd0,
        op_add  = 4'd1,
        op_sub  = 4'd2,
        op_and  = 4'd3,
        op_or   = 4'd4,
        op_xor  = 4'd5,
        op_addi = 4'd6,
        op_ld   = 4'd7,
        op_st   = 4'd8
    } opcode_e;

    ////////////////////
    // stage registers
    ////////////////////
    typedef struct packed {
        logic                   valid;
        logic [imem_addr_w-1:0] pc;
        logic [xlen-1:0]        instr;
    } fetch_t;

    typedef struct packed {
        logic                   valid;
        opcode_e                op;
        logic [reg_addr_w-1:0]  rd;
        logic                   we;
        logic [reg_addr_w-1:0]  rs1;
        // for st this carries the store source register
        logic [reg_addr_w-1:0]  rs2;
        logic [xlen-1:0]        a;
        logic [xlen-1:0]        b;
        logic [xlen-1:0]        imm;
        logic [imem_addr_w-1:0] pc;
    } decode_t;

    typedef struct packed {
        logic                   valid;
        opcode_e                op;
        logic [reg_addr_w-1:0]  rd;
        logic                   we;
        logic [xlen-1:0]        result;
        logic [xlen-1:0]        sdata;
        logic [imem_addr_w-1:0] pc;
    } exec_t;

    typedef struct packed {
        logic                   valid;
        logic [reg_addr_w-1:0]  rd;
        logic                   we;
        logic [xlen-1:0]        result;
        logic [imem_addr_w-1:0] pc;
    } wb_t;

    ////////////////////
    // trace
    ////////////////////
    typedef struct packed {
        logic [seq_w-1:0] seq;
        logic [cyc_w-1:0] fetch_cycle;
    } trace_tag_t;

    typedef struct packed {
        logic [seq_w-1:0]       seq;
        logic [imem_addr_w-1:0] pc;
        logic [reg_addr_w-1:0]  rd;
        logic                   we;
        logic [xlen-1:0]        result;
        logic [cyc_w-1:0]       fetch_cycle;
        logic [cyc_w-1:0]       retire_cycle;
    } retire_t;

endpackage

// File: hdl/instr_fetch.sv
// instruction fetch stage
module instr_fetch import pipe_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   run,
    input  logic                   stall,
    input  logic                   imem_we,
    input  logic [imem_addr_w-1:0] imem_addr,
    input  logic [xlen-1:0]        imem_wdata,
    output fetch_t                 fetch_out
);

    logic [xlen-1:0]        imem [imem_depth];
    logic [imem_addr_w-1:0] pc;

    // program load port, only open while the core sits in reset
    always_ff @(posedge clk) begin
        if (rst && imem_we) begin
            imem[imem_addr] <= imem_wdata;
        end
    end

    // pc advances on every accepted fetch, wraps at the end of imem
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (run && !stall) begin
            pc <= pc + 1'b1;
        end
    end

    // fetch/decode register
    // run low gives a bubble, stall keeps the current word for decode
    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_out.valid <= 1'b0;
        end else if (!stall) begin
            fetch_out.valid <= run;
            fetch_out.pc    <= pc;
            fetch_out.instr <= imem[pc];
        end
    end

    // a valid word sits one behind the pc, so a stall has to freeze both together
    a_pc_hold: assert property (@(posedge clk) disable iff (rst)
        fetch_out.valid |-> pc == fetch_out.pc + 1'b1);

endmodule

// File: hdl/decode_regfile.sv
// decode stage and register file
module decode_regfile import pipe_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  fetch_t  fetch_in,
    input  wb_t     wb_in,
    output logic    stall,
    output decode_t decode_out
);

    logic [xlen-1:0]       regs [reg_count];
    opcode_e               op;
    logic                  we;
    logic                  use_rs1;
    logic                  use_rs2;
    logic [reg_addr_w-1:0] rd;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] src2;
    logic [xlen-1:0]       rdata1;
    logic [xlen-1:0]       rdata2;
    logic [xlen-1:0]       imm;

    ////////////////////
    // field decode
    ////////////////////
    assign rd  = fetch_in.instr[11:9];
    assign rs1 = fetch_in.instr[8:6];
    assign rs2 = fetch_in.instr[5:3];
    assign imm = {{(xlen-6){fetch_in.instr[5]}}, fetch_in.instr[5:0]};

    // st reads its data from the rd field
    assign src2 = (op == op_st) ? rd : rs2;

    always_comb begin
        op      = op_nop;
        we      = 1'b0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        case (fetch_in.instr[15:12])
            op_add, op_sub, op_and, op_or, op_xor: begin
                op      = opcode_e'(fetch_in.instr[15:12]);
                we      = 1'b1;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            op_addi, op_ld: begin
                op      = opcode_e'(fetch_in.instr[15:12]);
                we      = 1'b1;
                use_rs1 = 1'b1;
            end
            op_st: begin
                op      = op_st;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            // unused encodings fall through as nop
            default: op = op_nop;
        endcase
    end

    ////////////////////
    // register file
    ////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_in.valid && wb_in.we) begin
            regs[wb_in.rd] <= wb_in.result;
        end
    end

    // write-back lands in the same cycle, so pass it straight through
    always_comb begin
        rdata1 = regs[rs1];
        rdata2 = regs[src2];
        if (wb_in.valid && wb_in.we && wb_in.rd == rs1) begin
            rdata1 = wb_in.result;
        end
        if (wb_in.valid && wb_in.we && wb_in.rd == src2) begin
            rdata2 = wb_in.result;
        end
    end

    // load in execute feeding the word in decode, wait one cycle
    assign stall = fetch_in.valid && decode_out.valid && decode_out.op == op_ld &&
                   ((use_rs1 && decode_out.rd == rs1) || (use_rs2 && decode_out.rd == src2));

    ////////////////////
    // decode/execute register
    ////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            decode_out.valid <= 1'b0;
        end else begin
            // stall sends a bubble on while the load moves ahead
            decode_out.valid <= fetch_in.valid && !stall;
        end
    end

    always_ff @(posedge clk) begin
        decode_out.op  <= op;
        decode_out.rd  <= rd;
        decode_out.we  <= we;
        decode_out.rs1 <= rs1;
        decode_out.rs2 <= src2;
        decode_out.a   <= rdata1;
        decode_out.b   <= rdata2;
        decode_out.imm <= imm;
        decode_out.pc  <= fetch_in.pc;
    end

    // the stalled word must still wait in fetch the cycle after
    a_fetch_hold: assert property (@(posedge clk) disable iff (rst)
        stall |=> $stable(fetch_in));

endmodule

// File: hdl/execute_alu.sv
// execute stage with forwarding
module execute_alu import pipe_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  decode_t decode_in,
    input  exec_t   mem_fwd,
    input  wb_t     wb_fwd,
    output exec_t   exec_out
);

    logic [xlen-1:0] opa;
    logic [xlen-1:0] opb;
    logic [xlen-1:0] alu;

    // youngest result wins, a load in mem has no data yet
    function automatic logic [xlen-1:0] pick(input logic [reg_addr_w-1:0] src,
                                             input logic [xlen-1:0]       rf_val);
        logic [xlen-1:0] val;
        val = rf_val;
        if (wb_fwd.valid && wb_fwd.we && wb_fwd.rd == src) begin
            val = wb_fwd.result;
        end
        if (mem_fwd.valid && mem_fwd.we && mem_fwd.op != op_ld && mem_fwd.rd == src) begin
            val = mem_fwd.result;
        end
        return val;
    endfunction

    assign opa = pick(decode_in.rs1, decode_in.a);
    assign opb = pick(decode_in.rs2, decode_in.b);

    always_comb begin
        case (decode_in.op)
            op_add:                alu = opa + opb;
            op_sub:                alu = opa - opb;
            op_and:                alu = opa & opb;
            op_or:                 alu = opa | opb;
            op_xor:                alu = opa ^ opb;
            // address or immediate sum
            op_addi, op_ld, op_st: alu = opa + decode_in.imm;
            default:               alu = '0;
        endcase
    end

    ////////////////////
    // execute/memory register
    ////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            exec_out.valid <= 1'b0;
        end else begin
            exec_out.valid <= decode_in.valid;
        end
    end

    always_ff @(posedge clk) begin
        exec_out.op     <= decode_in.op;
        exec_out.rd     <= decode_in.rd;
        exec_out.we     <= decode_in.we;
        exec_out.result <= alu;
        exec_out.sdata  <= opb;
        exec_out.pc     <= decode_in.pc;
    end

endmodule

// File: hdl/data_mem.sv
// memory stage
module data_mem import pipe_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  exec_t exec_in,
    output wb_t   wb_out
);

    logic [xlen-1:0]        dmem [dmem_depth];
    logic [dmem_addr_w-1:0] addr;
    logic [xlen-1:0]        rdata;

    // upper address bits are ignored
    assign addr  = exec_in.result[dmem_addr_w-1:0];
    assign rdata = dmem[addr];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < dmem_depth; i++) begin
                dmem[i] <= '0;
            end
        end else if (exec_in.valid && exec_in.op == op_st) begin
            dmem[addr] <= exec_in.sdata;
        end
    end

    ////////////////////
    // memory/write-back register
    ////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_out.valid <= 1'b0;
        end else begin
            wb_out.valid <= exec_in.valid;
        end
    end

    always_ff @(posedge clk) begin
        wb_out.rd     <= exec_in.rd;
        wb_out.we     <= exec_in.we;
        wb_out.result <= (exec_in.op == op_ld) ? rdata : exec_in.result;
        wb_out.pc     <= exec_in.pc;
    end

endmodule

// File: hdl/trace_unit.sv
// retire trace unit
module trace_unit import pipe_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    fetch_fire,
    input  logic    stall,
    input  wb_t     wb_in,
    output logic    retire_valid,
    output retire_t retire_rec
);

    logic [cyc_w-1:0] cyc_cnt;
    logic [cyc_w-1:0] hold_cyc;
    logic [seq_w-1:0] seq_cnt;
    logic [seq_w-1:0] exp_seq;
    logic             stall_q;
    trace_tag_t       fetch_tag;
    // decode, execute and memory slots
    trace_tag_t       tag_q [3];

    ////////////////////
    // counters
    ////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            cyc_cnt <= '0;
            seq_cnt <= '0;
            stall_q <= 1'b0;
        end else begin
            cyc_cnt <= cyc_cnt + 1'b1;
            stall_q <= stall;
            // numbers are handed out only when decode takes the word
            if (fetch_fire && !stall) begin
                seq_cnt <= seq_cnt + 1'b1;
            end
        end
    end

    // a stalled word keeps the cycle it first showed up in fetch
    always_ff @(posedge clk) begin
        if (stall) begin
            hold_cyc <= cyc_cnt;
        end
    end

    assign fetch_tag.seq         = seq_cnt;
    assign fetch_tag.fetch_cycle = stall_q ? hold_cyc : cyc_cnt;

    ////////////////////
    // tag pipeline
    ////////////////////
    // slots follow the stage registers, bubbles carry stale tags
    // which wb_in.valid masks out at the end
    always_ff @(posedge clk) begin
        tag_q[0] <= fetch_tag;
        tag_q[1] <= tag_q[0];
        tag_q[2] <= tag_q[1];
    end

    ////////////////////
    // retire record
    ////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= wb_in.valid;
        end
    end

    always_ff @(posedge clk) begin
        retire_rec.seq          <= tag_q[2].seq;
        retire_rec.pc           <= wb_in.pc;
        retire_rec.rd           <= wb_in.rd;
        retire_rec.we           <= wb_in.we;
        retire_rec.result       <= wb_in.result;
        retire_rec.fetch_cycle  <= tag_q[2].fetch_cycle;
        // record is seen one cycle after write-back
        retire_rec.retire_cycle <= cyc_cnt + 1'b1;
    end

    // next seq expected at retire
    always_ff @(posedge clk) begin
        if (rst) begin
            exp_seq <= '0;
        end else if (retire_valid) begin
            exp_seq <= exp_seq + 1'b1;
        end
    end

    // tags and stage valids must stay in step through every stall
    a_seq_order: assert property (@(posedge clk) disable iff (rst)
        retire_valid |-> retire_rec.seq == exp_seq);

endmodule

// File: hdl/cpu_core_top.sv
// five stage core top level
module cpu_core_top import pipe_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   run,
    input  logic                   imem_we,
    input  logic [imem_addr_w-1:0] imem_addr,
    input  logic [xlen-1:0]        imem_wdata,
    output logic                   retire_valid,
    output retire_t                retire_rec
);

    fetch_t  fetch_q;
    decode_t decode_q;
    exec_t   exec_q;
    wb_t     wb_q;
    logic    stall;
    logic    fetch_fire;

    // a valid word in the fetch register is a fetch for the trace
    assign fetch_fire = fetch_q.valid;

    ////////////////////
    // pipeline stages
    ////////////////////
    instr_fetch instr_fetch_inst (
        .clk        (clk),
        .rst        (rst),
        .run        (run),
        .stall      (stall),
        .imem_we    (imem_we),
        .imem_addr  (imem_addr),
        .imem_wdata (imem_wdata),
        .fetch_out  (fetch_q)
    );

    decode_regfile decode_regfile_inst (
        .clk        (clk),
        .rst        (rst),
        .fetch_in   (fetch_q),
        .wb_in      (wb_q),
        .stall      (stall),
        .decode_out (decode_q)
    );

    // memory and write-back registers loop back for forwarding
    execute_alu execute_alu_inst (
        .clk       (clk),
        .rst       (rst),
        .decode_in (decode_q),
        .mem_fwd   (exec_q),
        .wb_fwd    (wb_q),
        .exec_out  (exec_q)
    );

    data_mem data_mem_inst (
        .clk     (clk),
        .rst     (rst),
        .exec_in (exec_q),
        .wb_out  (wb_q)
    );

    ////////////////////
    // trace
    ////////////////////
    trace_unit trace_unit_inst (
        .clk          (clk),
        .rst          (rst),
        .fetch_fire   (fetch_fire),
        .stall        (stall),
        .wb_in        (wb_q),
        .retire_valid (retire_valid),
        .retire_rec   (retire_rec)
    );

endmodule

// File: bench/check_table.svh
// retire check table entry
`ifndef CHECK_TABLE_SVH
`define CHECK_TABLE_SVH

// part of the core an entry exercises, only used to name the check
typedef enum logic [2:0] {
    kind_alu,
    kind_fwd,
    kind_mem,
    kind_load_use,
    kind_order
} check_kind_e;

// one program slot and the retire record it should produce
typedef struct packed {
    logic [pipe_pkg::xlen-1:0]       instr;
    logic [pipe_pkg::reg_addr_w-1:0] rd;
    logic                            we;
    logic [pipe_pkg::xlen-1:0]       result;
    // retire_cycle minus fetch_cycle
    logic [3:0]                      lat;
    check_kind_e                     kind;
} check_entry_t;

`endif

// File: bench/retire_checker.sv
// retire record checker
`include "check_table.svh"

module retire_checker import pipe_pkg::*; #(
    parameter int n_entries = 1
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         retire_valid,
    input  retire_t      retire_rec,
    input  check_entry_t table_in [n_entries],
    output int           err_count,
    output int           retired_count
);

    timeunit 1ns;
    timeprecision 1ps;

    // next sequence number due at retire
    logic [seq_w-1:0] next_seq;
    // cycles since reset, zero in the first cycle out of reset
    int               now_cycle;

    function automatic string kind_name(input check_kind_e kind);
        case (kind)
            kind_alu:      return "alu";
            kind_fwd:      return "forward";
            kind_mem:      return "memory";
            kind_load_use: return "load_use";
            default:       return "order";
        endcase
    endfunction

    task automatic report_value(input string test, input string field,
                                input int expected, input int actual);
        $display("[ERROR] %s %s: expected 0x%0h actual 0x%0h", test, field, expected, actual);
        err_count++;
    endtask

    ////////////////////
    // retire port
    ////////////////////
    // record and valid are registered, so mid cycle they are settled
    always @(negedge clk) begin
        string        test;
        check_entry_t want;
        int           seq;
        int           lat;
        if (rst) begin
            next_seq      = '0;
            retired_count = 0;
            err_count     = 0;
            now_cycle     = 0;
        end else if (retire_valid) begin
            seq = int'(retire_rec.seq);
            lat = int'(retire_rec.retire_cycle - retire_rec.fetch_cycle);
            // in order, no gaps, no repeats
            if (retire_rec.seq != next_seq) begin
                report_value($sformatf("order_%0d", next_seq), "seq",
                             int'(next_seq), seq);
            end
            // pc only moves on an accepted fetch, so it tracks seq
            if (retire_rec.pc != retire_rec.seq[imem_addr_w-1:0]) begin
                report_value($sformatf("order_%0d", seq), "pc",
                             seq % imem_depth, int'(retire_rec.pc));
            end
            // retire cycle is the cycle the record shows up
            if (int'(retire_rec.retire_cycle) != now_cycle) begin
                report_value($sformatf("order_%0d", seq), "retire_cycle",
                             now_cycle, int'(retire_rec.retire_cycle));
            end
            if (seq < n_entries) begin
                want = table_in[seq];
                test = $sformatf("%s_%0d", kind_name(want.kind), seq);
                if (retire_rec.we != want.we) begin
                    report_value(test, "we", int'(want.we), int'(retire_rec.we));
                end
                // rd and result only carry meaning on a register write
                if (want.we && retire_rec.rd != want.rd) begin
                    report_value(test, "rd", int'(want.rd), int'(retire_rec.rd));
                end
                if (want.we && retire_rec.result != want.result) begin
                    report_value(test, "result", int'(want.result), int'(retire_rec.result));
                end
                if (lat != int'(want.lat)) begin
                    report_value(test, "latency", int'(want.lat), lat);
                end
                retired_count++;
            end else begin
                // past the table only the nop fill comes through
                test = $sformatf("fill_%0d", seq);
                if (retire_rec.we) begin
                    report_value(test, "we", 0, 1);
                end
            end
            next_seq = retire_rec.seq + 1'b1;
        end
        if (!rst) begin
            now_cycle++;
        end
    end

endmodule

// File: bench/cpu_core_tb.sv
// core retire testbench
`include "check_table.svh"

module cpu_core_tb import pipe_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int n_entries    = 21;
    localparam int reset_cycles = 5;
    localparam int drive_delay  = 2;
    // load, reset and start, then the table plus room to drain
    localparam int watchdog_cycles = imem_depth + 1 + reset_cycles + 1 + n_entries + 20;

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   run;
    logic                   imem_we;
    logic [imem_addr_w-1:0] imem_addr;
    logic [xlen-1:0]        imem_wdata;
    logic                   retire_valid;
    retire_t                retire_rec;
    int                     err_count;
    int                     retired_count;
    check_entry_t           prog [n_entries];

    // 40 ns period
    always #20 clk = ~clk;

    cpu_core_top cpu_core_top_inst (
        .clk          (clk),
        .rst          (rst),
        .run          (run),
        .imem_we      (imem_we),
        .imem_addr    (imem_addr),
        .imem_wdata   (imem_wdata),
        .retire_valid (retire_valid),
        .retire_rec   (retire_rec)
    );

    retire_checker #(.n_entries(n_entries)) retire_checker_inst (
        .clk           (clk),
        .rst           (rst),
        .retire_valid  (retire_valid),
        .retire_rec    (retire_rec),
        .table_in      (prog),
        .err_count     (err_count),
        .retired_count (retired_count)
    );

    ////////////////////
    // program table
    ////////////////////
    function automatic logic [xlen-1:0] alu_word(input opcode_e op, input int rd,
                                                 input int rs1, input int rs2);
        return {op, reg_addr_w'(rd), reg_addr_w'(rs1), reg_addr_w'(rs2), 3'b000};
    endfunction

    // addi, ld and st carry a signed 6 bit immediate in the low bits
    function automatic logic [xlen-1:0] imm_word(input opcode_e op, input int rd,
                                                 input int rs1, input int imm);
        return {op, reg_addr_w'(rd), reg_addr_w'(rs1), 6'(imm)};
    endfunction

    function automatic check_entry_t row(input logic [xlen-1:0] instr, input int rd,
                                         input logic we, input logic [xlen-1:0] result,
                                         input int lat, input check_kind_e kind);
        check_entry_t r;
        r.instr  = instr;
        r.rd     = reg_addr_w'(rd);
        r.we     = we;
        r.result = result;
        r.lat    = 4'(lat);
        r.kind   = kind;
        return r;
    endfunction

    task automatic build_program();
        // operands built with addi, then every alu op on them
        prog[0]  = row(imm_word(op_addi, 1, 0, 5), 1, 1'b1, 16'h0005, 4, kind_alu);
        prog[1]  = row(imm_word(op_addi, 2, 0, 12), 2, 1'b1, 16'h000c, 4, kind_alu);
        prog[2]  = row(imm_word(op_addi, 3, 0, -3), 3, 1'b1, 16'hfffd, 4, kind_alu);
        prog[3]  = row(alu_word(op_nop, 0, 0, 0), 0, 1'b0, 16'h0000, 4, kind_order);
        prog[4]  = row(alu_word(op_add, 4, 1, 2), 4, 1'b1, 16'h0011, 4, kind_alu);
        prog[5]  = row(alu_word(op_sub, 5, 2, 1), 5, 1'b1, 16'h0007, 4, kind_alu);
        prog[6]  = row(alu_word(op_and, 6, 2, 3), 6, 1'b1, 16'h000c, 4, kind_alu);
        prog[7]  = row(alu_word(op_or, 7, 1, 2), 7, 1'b1, 16'h000d, 4, kind_alu);
        prog[8]  = row(alu_word(op_xor, 4, 4, 3), 4, 1'b1, 16'hffec, 4, kind_alu);
        // each result feeds the next slot, from mem and from write-back
        prog[9]  = row(imm_word(op_addi, 1, 1, 1), 1, 1'b1, 16'h0006, 4, kind_fwd);
        prog[10] = row(alu_word(op_add, 2, 1, 1), 2, 1'b1, 16'h000c, 4, kind_fwd);
        prog[11] = row(alu_word(op_sub, 3, 2, 1), 3, 1'b1, 16'h0006, 4, kind_fwd);
        prog[12] = row(alu_word(op_xor, 4, 3, 2), 4, 1'b1, 16'h000a, 4, kind_fwd);
        // two stores, a load back and a load from an untouched word
        prog[13] = row(imm_word(op_st, 4, 0, 3), 4, 1'b0, 16'h0000, 4, kind_mem);
        prog[14] = row(imm_word(op_st, 2, 0, 7), 2, 1'b0, 16'h0000, 4, kind_mem);
        prog[15] = row(imm_word(op_ld, 6, 0, 3), 6, 1'b1, 16'h000a, 4, kind_mem);
        prog[16] = row(imm_word(op_ld, 7, 0, 5), 7, 1'b1, 16'h0000, 4, kind_mem);
        // load used in the very next slot, one bubble
        prog[17] = row(imm_word(op_ld, 1, 0, 7), 1, 1'b1, 16'h000c, 4, kind_load_use);
        prog[18] = row(alu_word(op_add, 2, 1, 1), 2, 1'b1, 16'h0018, 5, kind_load_use);
        prog[19] = row(imm_word(op_addi, 3, 2, 1), 3, 1'b1, 16'h0019, 4, kind_load_use);
        prog[20] = row(alu_word(op_nop, 0, 0, 0), 0, 1'b0, 16'h0000, 4, kind_order);
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #(drive_delay);
    endtask

    task automatic print_counts();
        $display("errors: %0d, retired %0d of %0d", err_count, retired_count, n_entries);
    endtask

    ////////////////////
    // main sequence
    ////////////////////
    initial begin
        rst        = 1'b1;
        run        = 1'b0;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        build_program();
        // whole imem written while rst is high, nop past the table
        for (int a = 0; a < imem_depth; a++) begin
            next_cycle();
            imem_we    = 1'b1;
            imem_addr  = imem_addr_w'(a);
            imem_wdata = (a < n_entries) ? prog[a].instr : alu_word(op_nop, 0, 0, 0);
        end
        next_cycle();
        imem_we = 1'b0;
        repeat (reset_cycles) next_cycle();
        rst = 1'b0;
        next_cycle();
        run = 1'b1;
        wait (retired_count == n_entries);
        // a few fill nops retire too before the end
        repeat (6) @(posedge clk);
        print_counts();
        if (err_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: instructions never retired within %0d cycles", watchdog_cycles);
        print_counts();
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// File: files.f
+incdir+bench
hdl/pipe_pkg.sv
hdl/instr_fetch.sv
hdl/decode_regfile.sv
hdl/execute_alu.sv
hdl/data_mem.sv
hdl/trace_unit.sv
hdl/cpu_core_top.sv
bench/retire_checker.sv
bench/cpu_core_tb.sv

// File: run.sh
#!/bin/sh
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module cpu_core_tb -f files.f -o sim_cpu_core
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_cpu_core)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -q '^STATUS: PASS$'; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1
